//--- design/warp_pkg.sv
package warp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes

    localparam int NUM_THREADS = 8;   // threads per warp
    localparam int IB_DEPTH    = 4;   // instruction buffer entries
    localparam int SCB_DEPTH   = 4;   // scoreboard entries
    localparam int IB_AW       = $clog2(IB_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // field types

    typedef logic [31:0]            instr_t;        // raw instruction word
    typedef logic [4:0]             reg_id_t;
    typedef logic [3:0]             alu_op_t;
    typedef logic [15:0]            imme_t;
    typedef logic [NUM_THREADS-1:0] active_mask_t;  // one bit per thread

    typedef logic [$clog2(SCB_DEPTH)-1:0] scb_id_t;
    typedef logic [IB_AW:0]               ib_ptr_t; // msb is the wrap bit

    // scoreboard entry life cycle
    typedef enum logic [1:0] {
        SCB_FREE,    // unused
        SCB_BUSY,    // waits for register writeback
        SCB_REPLAY   // load/store still being replayed
    } scb_state_t;

endpackage

//--- design/warp_ibuffer.sv
`timescale 1ns/1ps

module warp_ibuffer import warp_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // fetch
    input  logic         fetch_valid,
    output logic         fetch_req,

    // decode
    input  logic         dec_valid,
    input  instr_t       dec_instr,
    input  reg_id_t      dec_src1,
    input  reg_id_t      dec_src2,
    input  reg_id_t      dec_dst,
    input  logic         dec_src1_valid,
    input  logic         dec_src2_valid,
    input  logic         dec_dst_valid,
    input  alu_op_t      dec_alu_op,
    input  imme_t        dec_imme,
    input  logic         dec_reg_write,
    input  logic         dec_mem_read,
    input  logic         dec_mem_write,
    input  logic         dec_shared_mem,
    input  logic         dec_branch_eq,
    input  logic         dec_branch_lt,
    input  logic         dec_exit,
    input  logic         drop_instr,
    input  active_mask_t active_mask,

    // issue unit and operand collector
    input  logic         issue_grant,
    output logic         issue_req,
    output instr_t       issue_instr,
    output reg_id_t      issue_src1,
    output reg_id_t      issue_src2,
    output reg_id_t      issue_dst,
    output logic         issue_src1_valid,
    output logic         issue_src2_valid,
    output logic         issue_dst_valid,
    output alu_op_t      issue_alu_op,
    output imme_t        issue_imme,
    output logic         issue_reg_write,
    output logic         issue_mem_read,
    output logic         issue_mem_write,
    output logic         issue_shared_mem,
    output logic         issue_branch_eq,
    output logic         issue_branch_lt,
    output scb_id_t      issue_scb_id,

    // exit
    input  logic         exit_grant,
    output logic         exit_req,

    // scoreboard
    input  logic         scb_full,
    input  logic         scb_empty,
    input  logic         scb_dependent,
    input  scb_id_t      alloc_id,
    output logic         scb_alloc,
    output logic         scb_replayable,
    output logic         replay_done,
    output scb_id_t      replay_scb_id,

    // memory feedback for the oldest unfinished load/store
    input  logic         mem_pos_valid,
    input  active_mask_t mem_pos_mask,
    input  logic         mem_zero_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // entry storage

    logic [IB_DEPTH-1:0] valid_q, valid_d;
    logic [IB_DEPTH-1:0] rpend_q, rpend_d;   // marked for replay

    active_mask_t mask_q   [IB_DEPTH];
    instr_t       instr_q  [IB_DEPTH];
    reg_id_t      src1_q   [IB_DEPTH];
    reg_id_t      src2_q   [IB_DEPTH];
    reg_id_t      dst_q    [IB_DEPTH];
    alu_op_t      alu_op_q [IB_DEPTH];
    imme_t        imme_q   [IB_DEPTH];
    scb_id_t      scb_id_q [IB_DEPTH];

    logic [IB_DEPTH-1:0] src1_v_q, src2_v_q, dst_v_q;
    logic [IB_DEPTH-1:0] reg_write_q, mem_read_q, mem_write_q, shared_q;
    logic [IB_DEPTH-1:0] beq_q, blt_q, exit_q;

    // write, head and oldest-unfinished pointers
    ib_ptr_t wr_ptr, head_ptr, rp_ptr;
    ib_ptr_t head_next, rp_next, depth;

    logic [IB_AW-1:0] wr_idx, head_idx, rp_idx, sel_idx;

    logic         wr_en, ib_full, head_is_mem, mem_busy;
    logic         head_req, replay_req, head_grant, replay_grant, exit_take;
    logic         fb_more, done_now;
    active_mask_t mask_next;

    assign wr_idx   = wr_ptr[IB_AW-1:0];
    assign head_idx = head_ptr[IB_AW-1:0];
    assign rp_idx   = rp_ptr[IB_AW-1:0];

    assign wr_en   = dec_valid && !drop_instr;
    assign depth   = wr_ptr - rp_ptr;           // issued loads still hold a slot
    assign ib_full = depth == ib_ptr_t'(IB_DEPTH);

    assign fetch_req = (depth + ib_ptr_t'(fetch_valid) + ib_ptr_t'(wr_en))
                       < ib_ptr_t'(IB_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // replay and memory feedback

    assign mem_busy  = (rp_ptr != head_ptr) && valid_q[rp_idx];
    assign mask_next = mem_pos_valid ? (mask_q[rp_idx] & ~mem_pos_mask) : mask_q[rp_idx];
    assign done_now  = mem_busy && mem_pos_valid && (mask_next == '0);
    assign fb_more   = mem_busy && (mem_zero_valid || (mem_pos_valid && mask_next != '0));

    // replay first, a finishing load needs no further issue
    assign replay_req = mem_busy && !done_now && (rpend_q[rp_idx] || fb_more);

    assign head_is_mem = mem_read_q[head_idx] || mem_write_q[head_idx];

    // a second load/store waits until the first one is done
    assign head_req = valid_q[head_idx] && !exit_q[head_idx] && !replay_req
                      && !(head_is_mem && mem_busy) && !scb_full && !scb_dependent;

    assign issue_req    = head_req || replay_req;
    assign head_grant   = head_req && issue_grant;
    assign replay_grant = replay_req && issue_grant;

    assign exit_req  = valid_q[head_idx] && exit_q[head_idx] && scb_empty;
    assign exit_take = exit_req && exit_grant;

    assign scb_alloc      = head_grant;
    assign scb_replayable = head_is_mem;
    assign replay_done    = done_now;
    assign replay_scb_id  = scb_id_q[rp_idx];

    always_comb begin
        valid_d = valid_q;
        rpend_d = rpend_q;
        if (done_now) valid_d[rp_idx] = 1'b0;
        if (fb_more) rpend_d[rp_idx] = 1'b1;
        if (replay_grant) rpend_d[rp_idx] = 1'b0;   // this issue serves the feedback
        if (head_grant && !head_is_mem) valid_d[head_idx] = 1'b0;
        if (exit_take) valid_d[head_idx] = 1'b0;
        if (wr_en) begin
            valid_d[wr_idx] = 1'b1;
            rpend_d[wr_idx] = 1'b0;
        end
    end

    assign head_next = head_ptr + ib_ptr_t'(head_grant || exit_take);
    // once the oldest entry is gone everything up to the head has retired
    assign rp_next   = valid_d[rp_idx] ? rp_ptr : head_next;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr   <= '0;
            head_ptr <= '0;
            rp_ptr   <= '0;
            valid_q  <= '0;
            rpend_q  <= '0;
        end else begin
            wr_ptr   <= wr_ptr + ib_ptr_t'(wr_en);
            head_ptr <= head_next;
            rp_ptr   <= rp_next;
            valid_q  <= valid_d;
            rpend_q  <= rpend_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mask_q[wr_idx]      <= active_mask;
            instr_q[wr_idx]     <= dec_instr;
            src1_q[wr_idx]      <= dec_src1;
            src2_q[wr_idx]      <= dec_src2;
            dst_q[wr_idx]       <= dec_dst;
            src1_v_q[wr_idx]    <= dec_src1_valid;
            src2_v_q[wr_idx]    <= dec_src2_valid;
            dst_v_q[wr_idx]     <= dec_dst_valid;
            alu_op_q[wr_idx]    <= dec_alu_op;
            imme_q[wr_idx]      <= dec_imme;
            reg_write_q[wr_idx] <= dec_reg_write;
            mem_read_q[wr_idx]  <= dec_mem_read;
            mem_write_q[wr_idx] <= dec_mem_write;
            shared_q[wr_idx]    <= dec_shared_mem;
            beq_q[wr_idx]       <= dec_branch_eq;
            blt_q[wr_idx]       <= dec_branch_lt;
            exit_q[wr_idx]      <= dec_exit;
        end
        if (head_grant) scb_id_q[head_idx] <= alloc_id;
        if (mem_busy && mem_pos_valid) mask_q[rp_idx] <= mask_next;   // trim served threads
    end

    ////////////////////////////////////////////////////////////////////////////
    // issue mux, replay entry or head

    assign sel_idx = replay_req ? rp_idx : head_idx;

    assign issue_instr      = instr_q[sel_idx];
    assign issue_src1       = src1_q[sel_idx];
    assign issue_src2       = src2_q[sel_idx];
    assign issue_dst        = dst_q[sel_idx];
    assign issue_src1_valid = src1_v_q[sel_idx];
    assign issue_src2_valid = src2_v_q[sel_idx];
    assign issue_dst_valid  = dst_v_q[sel_idx];
    assign issue_alu_op     = alu_op_q[sel_idx];
    assign issue_imme       = imme_q[sel_idx];
    assign issue_reg_write  = reg_write_q[sel_idx];
    assign issue_mem_read   = mem_read_q[sel_idx];
    assign issue_mem_write  = mem_write_q[sel_idx];
    assign issue_shared_mem = shared_q[sel_idx];
    assign issue_branch_eq  = beq_q[sel_idx];
    assign issue_branch_lt  = blt_q[sel_idx];
    // a head issue gets its entry from the scoreboard this cycle
    assign issue_scb_id     = replay_req ? scb_id_q[rp_idx] : alloc_id;

    // decode must honour fetch_req
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst)
        dec_valid |-> !ib_full)
        else $error("decode strobe while instruction buffer is full");

    a_grant_needs_req: assert property (@(posedge clk) disable iff (!rst)
        issue_grant |-> issue_req)
        else $error("issue grant without a pending request");

endmodule

//--- design/warp_scoreboard.sv
`timescale 1ns/1ps

module warp_scoreboard import warp_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    // allocation on a head issue
    input  logic    alloc,
    input  reg_id_t alloc_dst,
    input  logic    alloc_dst_valid,
    input  logic    alloc_replayable,

    // registers of the instruction at the head
    input  reg_id_t chk_src1,
    input  reg_id_t chk_src2,
    input  reg_id_t chk_dst,
    input  logic    chk_src1_valid,
    input  logic    chk_src2_valid,
    input  logic    chk_dst_valid,

    // clearing
    input  logic    wb_valid,
    input  scb_id_t wb_scb_id,
    input  logic    replay_done,
    input  scb_id_t replay_scb_id,

    output scb_id_t alloc_id,
    output logic    full,
    output logic    empty,
    output logic    dependent
);

    scb_state_t state_q [SCB_DEPTH];
    reg_id_t    dst_q   [SCB_DEPTH];
    logic [SCB_DEPTH-1:0] dst_valid_q;   // stores have no destination

    logic [SCB_DEPTH-1:0] free_vec;
    logic [SCB_DEPTH-1:0] hit_vec;
    logic                 take;

    always_comb begin
        for (int i = 0; i < SCB_DEPTH; i++) begin
            free_vec[i] = state_q[i] == SCB_FREE;
            // RAW on either source, WAW on the destination
            hit_vec[i]  = !free_vec[i] && dst_valid_q[i]
                          && ((chk_src1_valid && chk_src1 == dst_q[i])
                           || (chk_src2_valid && chk_src2 == dst_q[i])
                           || (chk_dst_valid && chk_dst == dst_q[i]));
        end
    end

    // lowest free entry wins
    always_comb begin
        alloc_id = '0;
        for (int i = SCB_DEPTH - 1; i >= 0; i--) begin
            if (free_vec[i]) alloc_id = scb_id_t'(i);
        end
    end

    assign full      = ~|free_vec;
    assign empty     = &free_vec;
    assign dependent = |hit_vec;

    // nothing to track without a destination or a replay
    assign take = alloc && (alloc_dst_valid || alloc_replayable);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < SCB_DEPTH; i++) begin
                state_q[i] <= SCB_FREE;
            end
        end else begin
            if (wb_valid) state_q[wb_scb_id] <= SCB_FREE;
            if (replay_done) state_q[replay_scb_id] <= SCB_FREE;
            if (take) state_q[alloc_id] <= alloc_replayable ? SCB_REPLAY : SCB_BUSY;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dst_q[alloc_id]       <= alloc_dst;
            dst_valid_q[alloc_id] <= alloc_dst_valid;
        end
    end

    // buffer only issues while the scoreboard has room
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> !full)
        else $error("scoreboard allocation while full");

    a_wb_busy: assert property (@(posedge clk) disable iff (!rst)
        wb_valid |-> state_q[wb_scb_id] == SCB_BUSY)
        else $error("writeback to a scoreboard entry that is not busy");

    a_replay_clear: assert property (@(posedge clk) disable iff (!rst)
        replay_done |-> state_q[replay_scb_id] == SCB_REPLAY)
        else $error("replay completion for a scoreboard entry not in replay");

endmodule

//--- design/warp_issue_front.sv
`timescale 1ns/1ps

module warp_issue_front import warp_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    input  logic         fetch_valid,
    output logic         fetch_req,

    input  logic         dec_valid,
    input  instr_t       dec_instr,
    input  reg_id_t      dec_src1,
    input  reg_id_t      dec_src2,
    input  reg_id_t      dec_dst,
    input  logic         dec_src1_valid,
    input  logic         dec_src2_valid,
    input  logic         dec_dst_valid,
    input  alu_op_t      dec_alu_op,
    input  imme_t        dec_imme,
    input  logic         dec_reg_write,
    input  logic         dec_mem_read,
    input  logic         dec_mem_write,
    input  logic         dec_shared_mem,
    input  logic         dec_branch_eq,
    input  logic         dec_branch_lt,
    input  logic         dec_exit,
    input  logic         drop_instr,
    input  active_mask_t active_mask,

    input  logic         issue_grant,
    output logic         issue_req,
    output instr_t       issue_instr,
    output reg_id_t      issue_src1,
    output reg_id_t      issue_src2,
    output reg_id_t      issue_dst,
    output logic         issue_src1_valid,
    output logic         issue_src2_valid,
    output logic         issue_dst_valid,
    output alu_op_t      issue_alu_op,
    output imme_t        issue_imme,
    output logic         issue_reg_write,
    output logic         issue_mem_read,
    output logic         issue_mem_write,
    output logic         issue_shared_mem,
    output logic         issue_branch_eq,
    output logic         issue_branch_lt,
    output scb_id_t      issue_scb_id,

    input  logic         exit_grant,
    output logic         exit_req,

    input  logic         mem_pos_valid,
    input  active_mask_t mem_pos_mask,
    input  logic         mem_zero_valid,

    input  logic         wb_valid,
    input  scb_id_t      wb_scb_id
);

    // buffer to scoreboard
    logic    scb_full, scb_empty, scb_dependent;
    logic    scb_alloc, scb_replayable, replay_done;
    scb_id_t alloc_id, replay_scb_id;

    warp_ibuffer u_ibuffer (.*);

    // the issued register fields double as the dependence check
    warp_scoreboard u_scoreboard (
        .clk              (clk),
        .rst              (rst),
        .alloc            (scb_alloc),
        .alloc_dst        (issue_dst),
        .alloc_dst_valid  (issue_dst_valid),
        .alloc_replayable (scb_replayable),
        .chk_src1         (issue_src1),
        .chk_src2         (issue_src2),
        .chk_dst          (issue_dst),
        .chk_src1_valid   (issue_src1_valid),
        .chk_src2_valid   (issue_src2_valid),
        .chk_dst_valid    (issue_dst_valid),
        .wb_valid         (wb_valid),
        .wb_scb_id        (wb_scb_id),
        .replay_done      (replay_done),
        .replay_scb_id    (replay_scb_id),
        .alloc_id         (alloc_id),
        .full             (scb_full),
        .empty            (scb_empty),
        .dependent        (scb_dependent)
    );

endmodule

//--- test/tb_warp_issue_front.sv
`timescale 1ns/1ps

module tb_warp_issue_front import warp_pkg::*; ();

    localparam string DATA_FILE = "test/warp_issue_testdata.txt";

    logic         clk = 1'b0;
    logic         rst;
    logic         fetch_valid, fetch_req;
    logic         dec_valid;
    instr_t       dec_instr;
    reg_id_t      dec_src1, dec_src2, dec_dst;
    logic         dec_src1_valid, dec_src2_valid, dec_dst_valid;
    alu_op_t      dec_alu_op;
    imme_t        dec_imme;
    logic         dec_reg_write, dec_mem_read, dec_mem_write, dec_shared_mem;
    logic         dec_branch_eq, dec_branch_lt, dec_exit, drop_instr;
    active_mask_t active_mask;
    logic         issue_grant, issue_req;
    instr_t       issue_instr;
    reg_id_t      issue_src1, issue_src2, issue_dst;
    logic         issue_src1_valid, issue_src2_valid, issue_dst_valid;
    alu_op_t      issue_alu_op;
    imme_t        issue_imme;
    logic         issue_reg_write, issue_mem_read, issue_mem_write, issue_shared_mem;
    logic         issue_branch_eq, issue_branch_lt;
    scb_id_t      issue_scb_id;
    logic         exit_grant, exit_req;
    logic         mem_pos_valid, mem_zero_valid;
    active_mask_t mem_pos_mask;
    logic         wb_valid;
    scb_id_t      wb_scb_id;

    logic        grant_on   = 1'b1;
    logic        grant_roll = 1'b0;
    int unsigned lcg_state  = 2292;
    int          errors     = 0;
    int          checks     = 0;
    int          n_lines    = 0;

    // issues seen at the DUT, oldest first
    instr_t  got_instr[$];
    reg_id_t got_dst[$];
    scb_id_t got_scb[$];
    bit      got_replay[$];

    // src1, src2, valid bits, alu op, immediate and control flags packed together
    logic [38:0] got_fields[$];
    logic [38:0] dec_fields[instr_t];   // by instruction word, as written

    warp_issue_front dut (.*);

    always #2 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;   // low bits of the lcg just alternate
    endfunction

    // the issue unit only grants a pending request
    assign issue_grant = grant_roll && issue_req;

    always @(posedge clk) begin
        grant_roll <= rst && grant_on && (lcg_next() % 2 == 0);
    end

    always @(posedge clk) begin
        if (rst && issue_req && issue_grant) begin
            got_instr.push_back(issue_instr);
            got_dst.push_back(issue_dst);
            got_scb.push_back(issue_scb_id);
            got_replay.push_back(!dut.scb_alloc);   // replay allocates nothing
            got_fields.push_back({issue_src1, issue_src2, issue_src1_valid,
                                  issue_src2_valid, issue_dst_valid, issue_alu_op,
                                  issue_imme, issue_reg_write, issue_mem_read,
                                  issue_mem_write, issue_shared_mem, issue_branch_eq,
                                  issue_branch_lt});
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_id(input reg_id_t got, input reg_id_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_alu_op(input alu_op_t got, input alu_op_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_imme(input imme_t got, input imme_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_scb_id(input scb_id_t got, input scb_id_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic decode_instr(input instr_t ins, input reg_id_t s1, s2, d,
                                input logic [2:0] vld, input alu_op_t op, input imme_t imm,
                                input logic [6:0] fl, input active_mask_t m, input logic drop);
        @(posedge clk);
        while (!fetch_req) @(posedge clk);
        dec_valid   <= 1'b1;
        dec_instr   <= ins;
        dec_src1    <= s1;
        dec_src2    <= s2;
        dec_dst     <= d;
        dec_alu_op  <= op;
        dec_imme    <= imm;
        active_mask <= m;
        drop_instr  <= drop;
        {dec_dst_valid, dec_src2_valid, dec_src1_valid} <= vld;
        {dec_exit, dec_branch_lt, dec_branch_eq, dec_shared_mem,
         dec_mem_write, dec_mem_read, dec_reg_write} <= fl;
        if (!drop) begin
            dec_fields[ins] = {s1, s2, vld[0], vld[1], vld[2], op, imm,
                               fl[0], fl[1], fl[2], fl[3], fl[4], fl[5]};
        end
        @(posedge clk);
        dec_valid <= 1'b0;
    endtask

    task automatic expect_issue(input instr_t ins, input reg_id_t d, input scb_id_t id,
                                input bit replay);
        logic [38:0] got_f;
        logic [38:0] exp_f;
        while (got_instr.size() == 0) @(posedge clk);
        check_instr(got_instr.pop_front(), ins, "issued instr");
        check_reg_id(got_dst.pop_front(), d, "issued dst");
        check_scb_id(got_scb.pop_front(), id, "issued scoreboard id");
        check_flag(got_replay.pop_front(), replay, "replay issue");
        got_f = got_fields.pop_front();
        exp_f = dec_fields.exists(ins) ? dec_fields[ins] : '0;
        check_reg_id(got_f[38:34], exp_f[38:34], "issued src1");
        check_reg_id(got_f[33:29], exp_f[33:29], "issued src2");
        check_alu_op(got_f[25:22], exp_f[25:22], "issued alu op");
        check_imme(got_f[21:6], exp_f[21:6], "issued imme");
        for (int i = 26; i <= 28; i++) begin
            check_flag(got_f[i], exp_f[i], "issued register valid bit");
        end
        for (int i = 0; i <= 5; i++) begin
            check_flag(got_f[i], exp_f[i], "issued control flag");
        end
    endtask

    task automatic send_feedback(input bit pos, input active_mask_t m, input bit done,
                                 input scb_id_t id);
        @(posedge clk);
        mem_pos_valid  <= pos;
        mem_zero_valid <= !pos;
        mem_pos_mask   <= m;
        @(posedge clk);
        check_flag(dut.replay_done, done, "replay_done");
        if (done) check_scb_id(dut.replay_scb_id, id, "replay_done scoreboard id");
        mem_pos_valid  <= 1'b0;
        mem_zero_valid <= 1'b0;
    endtask

    task automatic write_back(input scb_id_t id);
        @(posedge clk);
        wb_valid  <= 1'b1;
        wb_scb_id <= id;
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic take_exit();
        @(posedge clk);
        while (!exit_req) @(posedge clk);
        exit_grant <= 1'b1;
        @(posedge clk);
        exit_grant <= 1'b0;
    endtask

    task automatic check_level(input bit sel, input bit exp);
        @(posedge clk);
        if (sel) check_flag(exit_req, exp, "exit_req");
        else check_flag(fetch_req, exp, "fetch_req");
    endtask

    task automatic run_command(input string line);
        byte         cmd;
        int          n;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8, f9;
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h",
                    cmd, f0, f1, f2, f3, f4, f5, f6, f7, f8, f9);
        case (cmd)
            "D": decode_instr(instr_t'(f0), reg_id_t'(f1), reg_id_t'(f2), reg_id_t'(f3),
                              f4[2:0], alu_op_t'(f5), imme_t'(f6), f7[6:0],
                              active_mask_t'(f8), f9[0]);
            "E": expect_issue(instr_t'(f0), reg_id_t'(f1), scb_id_t'(f2), f3[0]);
            "F": send_feedback(f0[0], active_mask_t'(f1), f2[0], scb_id_t'(f3));
            "W": write_back(scb_id_t'(f0));
            "X": take_exit();
            "G": grant_on <= f0[0];
            "C": check_level(f0[0], f1[0]);
            default: begin
                errors++;
                $display("unknown command in data file: %s", line);
            end
        endcase
    endtask

    // about 200 cycles for each line of the data file
    initial begin
        wait (n_lines > 0);
        repeat (200 * n_lines) @(posedge clk);
        $display("timeout: the DUT stopped answering before the data file was done");
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        rst            = 1'b0;
        fetch_valid    = 1'b0;
        dec_valid      = 1'b0;
        dec_instr      = '0;
        dec_src1       = '0;
        dec_src2       = '0;
        dec_dst        = '0;
        dec_alu_op     = '0;
        dec_imme       = '0;
        active_mask    = '0;
        drop_instr     = 1'b0;
        exit_grant     = 1'b0;
        mem_pos_valid  = 1'b0;
        mem_zero_valid = 1'b0;
        mem_pos_mask   = '0;
        wb_valid       = 1'b0;
        wb_scb_id      = '0;
        {dec_src1_valid, dec_src2_valid, dec_dst_valid} = '0;
        {dec_reg_write, dec_mem_read, dec_mem_write, dec_shared_mem} = '0;
        {dec_branch_eq, dec_branch_lt, dec_exit} = '0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the data file %s", DATA_FILE);
        end else begin
            while ($fgets(line, fd) != 0) n_lines++;
            $fclose(fd);
        end

        repeat (10) @(posedge clk);
        rst <= 1'b1;

        if (errors == 0) begin
            fd = $fopen(DATA_FILE, "r");
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") run_command(line);
            end
            $fclose(fd);
            repeat (20) @(posedge clk);   // room for stray issues
            if (got_instr.size() != 0) begin
                errors++;
                $display("%0d instructions issued that the data file does not expect",
                         got_instr.size());
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- test/warp_issue_testdata.txt
# D instr src1 src2 dst valid(b0 src1,b1 src2,b2 dst) alu imme flags mask drop
# E instr dst scb replay | F pos mask done scb | W scb | X | G grant | C sel(0 fetch,1 exit) level
D 002081b3 1 2 3 7 1 0010 01 ff 0
D 0badf00d 1 2 4 7 1 0000 01 ff 1
D 004182b3 3 4 5 7 1 0000 01 ff 0
E 002081b3 3 0 0
W 0
E 004182b3 5 0 0
D 00412303 2 0 6 5 0 0004 03 0f 0
D 001303b3 6 1 7 7 1 0000 01 ff 0
E 00412303 6 1 0
F 1 03 0 0
E 00412303 6 1 1
F 0 00 0 0
E 00412303 6 1 1
F 1 0c 1 1
E 001303b3 7 1 0
G 0
D 00208063 1 2 0 3 0 0000 10 ff 0
D 00208463 1 2 0 3 0 0008 10 f0 0
D 0020c063 1 2 0 3 0 0000 20 0f 0
D 00209063 1 2 0 3 0 0000 10 ff 0
C 0 0
G 1
E 00208063 0 2 0
C 0 1
E 00208463 0 2 0
E 0020c063 0 2 0
E 00209063 0 2 0
D 0000006b 0 0 0 0 0 0000 40 ff 0
C 1 0
W 0
W 1
X
C 1 0

//--- sources.f
design/warp_pkg.sv
design/warp_ibuffer.sv
design/warp_scoreboard.sv
design/warp_issue_front.sv
test/tb_warp_issue_front.sv

//--- Bender.yml
package:
  name: warp_issue_front

sources:
  - design/warp_pkg.sv
  - design/warp_ibuffer.sv
  - design/warp_scoreboard.sv
  - design/warp_issue_front.sv
  - target: test
    files:
      - test/tb_warp_issue_front.sv
